// ==== src/amp_cfg.svh ====
`ifndef AMP_CFG_SVH
`define AMP_CFG_SVH

//////////////////////////////////////////////////////////////////////
// SPI link timing
//////////////////////////////////////////////////////////////////////

// AMP_CS cycles per sck half period
// The receiver needs at least 3 to turn dout around before the next rising edge
`define AMP_SCK_DIV 4
// Bits per frame, gain A nibble first
`define AMP_FRAME_BITS 8
// Length of the shdn high pulse in AMP_CS cycles
`define AMP_SHDN_CYCLES 16

//////////////////////////////////////////////////////////////////////
// AXI4-Lite register map
//////////////////////////////////////////////////////////////////////

`define AMP_AXIL_ADDR_W 4
`define AMP_AXIL_DATA_W 32
`define AMP_ADDR_GAIN 4'h0
`define AMP_ADDR_CMD 4'h4
`define AMP_ADDR_STATUS 4'h8

`endif

// ==== src/amp_pkg.sv ====
package amp_pkg;

	// Gain code of one channel, only 1 to 7 are legal
	typedef logic [3:0] gain_code_t;

	// One SPI frame as it goes out on mosi, MSB first
	typedef struct packed {
		gain_code_t gain_a;
		gain_code_t gain_b;
	} amp_frame_t;

	// Result of the last chip select window seen by the amplifier
	typedef enum logic [2:0] {
		st_none     = 3'd0,
		st_ok       = 3'd1,
		st_no_reset = 3'd2,
		st_short    = 3'd3,
		st_long     = 3'd4,
		st_bad_code = 3'd5
	} frame_status_t;

	// Request from the register block to the SPI master
	typedef enum logic {
		cmd_frame    = 1'b0,
		cmd_shutdown = 1'b1
	} amp_cmd_t;

	// STATUS word
	// gain_a [23:20], gain_b [19:16], readback [15:8], frame_status [6:4], busy [0]
	typedef struct packed {
		logic [7:0]    rsvd_hi;
		gain_code_t    gain_a;
		gain_code_t    gain_b;
		amp_frame_t    readback;
		logic          rsvd_mid;
		frame_status_t frame_status;
		logic [2:0]    rsvd_lo;
		logic          busy;
	} amp_status_t;

endpackage

// ==== src/spi_amp_if.sv ====
`timescale 1ns/1ps

interface spi_amp_if;

	// Serial clock, idles low between frames
	logic sck;
	// Data towards the amplifier, changes on falling sck
	logic mosi;
	// Chip select, low for exactly one frame
	logic cs_n;
	// Shutdown line, a full pulse arms the amplifier
	logic shdn;
	// Previously held setting shifted back, changes on falling sck
	logic dout;

	// Controller side of the link
	modport master (
		output sck,
		output mosi,
		output cs_n,
		output shdn,
		input  dout
	);

	// Amplifier side of the link
	modport amp (
		input  sck,
		input  mosi,
		input  cs_n,
		input  shdn,
		output dout
	);

endinterface

// ==== src/amp_axil_regs.sv ====
`timescale 1ns/1ps
`include "amp_cfg.svh"

module amp_axil_regs (
	input  logic                          AMP_CS,
	input  logic                          reseted,
	// Write address, data and response
	input  logic [`AMP_AXIL_ADDR_W-1:0]   awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`AMP_AXIL_DATA_W-1:0]   wdata,
	input  logic [`AMP_AXIL_DATA_W/8-1:0] wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	// Read address and data
	input  logic [`AMP_AXIL_ADDR_W-1:0]   araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [`AMP_AXIL_DATA_W-1:0]   rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	// SPI master and receiver side
	output logic                          start,
	output amp_pkg::amp_cmd_t             cmd,
	output amp_pkg::amp_frame_t           gain_word,
	input  logic                          busy,
	input  amp_pkg::amp_frame_t           readback,
	input  amp_pkg::frame_status_t        frame_status,
	input  amp_pkg::gain_code_t           gain_a,
	input  amp_pkg::gain_code_t           gain_b
);

	localparam int DW = `AMP_AXIL_DATA_W;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic wr_ready_q;
	logic wr_fire;
	logic rd_fire;
	logic wr_mapped;
	logic rd_mapped;
	amp_pkg::amp_status_t status_word;

	//////////////////////////////////////////////////////////////////////
	// Write channel
	//////////////////////////////////////////////////////////////////////

	// AW and W are taken together in one beat
	assign awready = wr_ready_q;
	assign wready = wr_ready_q;
	assign wr_fire = wr_ready_q & awvalid & wvalid;
	// STATUS is read only, writes to it are ignored
	assign wr_mapped = (awaddr == `AMP_ADDR_GAIN) || (awaddr == `AMP_ADDR_CMD) ||
		(awaddr == `AMP_ADDR_STATUS);

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			wr_ready_q <= 1'b0;
			bvalid <= 1'b0;
			start <= 1'b0;
		end else begin
			// One-cycle ready, held off while a response waits or the master works
			wr_ready_q <= awvalid & wvalid & ~wr_ready_q & ~bvalid & ~busy & ~start;
			// Bit 0 asks for a frame, bit 1 for a shutdown pulse
			start <= wr_fire & (awaddr == `AMP_ADDR_CMD) & wstrb[0] & (wdata[0] | wdata[1]);
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// GAIN register, low byte only
	always_ff @(posedge AMP_CS) begin
		if (reseted)
			gain_word <= '0;
		else if (wr_fire && awaddr == `AMP_ADDR_GAIN && wstrb[0])
			gain_word <= amp_pkg::amp_frame_t'(wdata[7:0]);
	end

	// Shutdown wins if both command bits are set
	always_ff @(posedge AMP_CS) begin
		if (wr_fire) begin
			bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
			cmd <= wdata[1] ? amp_pkg::cmd_shutdown : amp_pkg::cmd_frame;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////////////////////////

	assign rd_fire = arready & arvalid;
	assign rd_mapped = (araddr == `AMP_ADDR_GAIN) || (araddr == `AMP_ADDR_CMD) ||
		(araddr == `AMP_ADDR_STATUS);

	always_comb begin
		status_word = '0;
		status_word.busy = busy;
		status_word.frame_status = frame_status;
		status_word.readback = readback;
		status_word.gain_a = gain_a;
		status_word.gain_b = gain_b;
	end

	// Ready idles high whenever no read data is pending
	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else if (rd_fire) begin
			arready <= 1'b0;
			rvalid <= 1'b1;
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
				arready <= 1'b1;
			end
		end else begin
			arready <= 1'b1;
		end
	end

	// CMD reads back as zero
	always_ff @(posedge AMP_CS) begin
		if (rd_fire) begin
			rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
			case (araddr)
				`AMP_ADDR_GAIN: rdata <= DW'(gain_word);
				`AMP_ADDR_STATUS: rdata <= DW'(status_word);
				default: rdata <= '0;
			endcase
		end
	end

	// A command is only issued to a master that has gone idle
	start_idle_only: assert property (@(posedge AMP_CS) disable iff (reseted)
		start |-> !busy);

endmodule

// ==== src/amp_spi_master.sv ====
`timescale 1ns/1ps
`include "amp_cfg.svh"

module amp_spi_master (
	input  logic                AMP_CS,
	input  logic                reseted,
	input  logic                start,
	input  amp_pkg::amp_cmd_t   cmd,
	input  amp_pkg::amp_frame_t gain_word,
	output logic                busy,
	output amp_pkg::amp_frame_t readback,
	spi_amp_if.master           spi
);

	// One counter serves the shdn pulse and the sck half periods
	localparam int CNT_MAX = (`AMP_SHDN_CYCLES > `AMP_SCK_DIV) ? `AMP_SHDN_CYCLES : `AMP_SCK_DIV;
	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam int BIT_W = $clog2(`AMP_FRAME_BITS);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`AMP_SCK_DIV - 1);
	localparam logic [CNT_W-1:0] SHDN_LAST = CNT_W'(`AMP_SHDN_CYCLES - 1);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`AMP_FRAME_BITS - 1);

	typedef enum logic [2:0] {
		idle,
		shdn_pulse,
		select,
		shift,
		deselect
	} state_t;

	state_t state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [BIT_W-1:0] bit_q;
	logic sck_q;
	logic cs_n_q;
	logic shdn_q;
	logic [`AMP_FRAME_BITS-1:0] tx_q;
	logic [`AMP_FRAME_BITS-1:0] rx_q;

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			state_q <= idle;
			cnt_q <= '0;
			bit_q <= '0;
			sck_q <= 1'b0;
			cs_n_q <= 1'b1;
			shdn_q <= 1'b0;
			tx_q <= '0;
			rx_q <= '0;
			readback <= '0;
			busy <= 1'b0;
		end else begin
			case (state_q)
				idle: begin
					cnt_q <= '0;
					bit_q <= '0;
					if (start) begin
						busy <= 1'b1;
						if (cmd == amp_pkg::cmd_shutdown) begin
							shdn_q <= 1'b1;
							state_q <= shdn_pulse;
						end else begin
							// First bit is on mosi as soon as cs_n falls
							cs_n_q <= 1'b0;
							tx_q <= gain_word;
							state_q <= select;
						end
					end
				end
				shdn_pulse: begin
					if (cnt_q == SHDN_LAST) begin
						shdn_q <= 1'b0;
						state_q <= deselect;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				// First low half with sck idle
				select: begin
					if (cnt_q == HALF_LAST) begin
						cnt_q <= '0;
						sck_q <= 1'b1;
						rx_q <= {rx_q[`AMP_FRAME_BITS-2:0], spi.dout};
						state_q <= shift;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				shift: begin
					if (cnt_q == HALF_LAST) begin
						cnt_q <= '0;
						if (sck_q) begin
							// Falling edge moves the next bit onto mosi
							sck_q <= 1'b0;
							tx_q <= {tx_q[`AMP_FRAME_BITS-2:0], 1'b0};
							bit_q <= bit_q + 1'b1;
							if (bit_q == BIT_LAST)
								state_q <= deselect;
						end else begin
							sck_q <= 1'b1;
							rx_q <= {rx_q[`AMP_FRAME_BITS-2:0], spi.dout};
						end
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				// Hold cs_n low one more half period, then release busy a cycle later
				deselect: begin
					if (cs_n_q) begin
						busy <= 1'b0;
						state_q <= idle;
					end else if (cnt_q == HALF_LAST) begin
						cs_n_q <= 1'b1;
						readback <= amp_pkg::amp_frame_t'(rx_q);
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: state_q <= idle;
			endcase
		end
	end

	assign spi.sck = sck_q;
	assign spi.cs_n = cs_n_q;
	assign spi.shdn = shdn_q;
	assign spi.mosi = tx_q[`AMP_FRAME_BITS-1];

	// Amplifier never sees a frame while it is held in shutdown
	shdn_excl_cs: assert property (@(posedge AMP_CS) disable iff (reseted)
		!(spi.shdn && !spi.cs_n));
	// sck idles low at the start of every frame so its first edge is rising
	cs_fall_sck_low: assert property (@(posedge AMP_CS) disable iff (reseted)
		$fell(spi.cs_n) |-> !spi.sck);

endmodule

// ==== src/amp_gain_receiver.sv ====
`timescale 1ns/1ps
`include "amp_cfg.svh"

module amp_gain_receiver (
	input  logic                   AMP_CS,
	input  logic                   reseted,
	spi_amp_if.amp                 spi,
	output amp_pkg::gain_code_t    gain_a,
	output amp_pkg::gain_code_t    gain_b,
	output amp_pkg::frame_status_t frame_status
);

	localparam logic [3:0] FRAME_LEN = 4'(`AMP_FRAME_BITS);

	logic sck_q;
	logic sck_prev_q;
	logic cs_n_q;
	logic cs_n_prev_q;
	logic shdn_q;
	logic shdn_prev_q;
	logic mosi_q;
	logic sck_rise;
	logic sck_fall;
	logic cs_fall;
	logic cs_rise;
	logic shdn_fall;
	logic armed_q;
	logic [3:0] bit_cnt_q;
	logic [`AMP_FRAME_BITS-1:0] in_q;
	logic [`AMP_FRAME_BITS-1:0] out_q;
	amp_pkg::amp_frame_t rx_frame;

	// Legal codes are 1 to 7
	function automatic logic code_ok(input amp_pkg::gain_code_t code);
		return (code != 4'd0) && !code[3];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Line sampling and edge detection
	//////////////////////////////////////////////////////////////////////

	// Sample stage, then previous value for edges
	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			sck_q <= 1'b0;
			sck_prev_q <= 1'b0;
			cs_n_q <= 1'b1;
			cs_n_prev_q <= 1'b1;
			shdn_q <= 1'b0;
			shdn_prev_q <= 1'b0;
			mosi_q <= 1'b0;
		end else begin
			sck_q <= spi.sck;
			cs_n_q <= spi.cs_n;
			shdn_q <= spi.shdn;
			mosi_q <= spi.mosi;
			sck_prev_q <= sck_q;
			cs_n_prev_q <= cs_n_q;
			shdn_prev_q <= shdn_q;
		end
	end

	// sck only counts inside a chip select window
	assign sck_rise = sck_q & ~sck_prev_q & ~cs_n_q;
	assign sck_fall = ~sck_q & sck_prev_q & ~cs_n_q;
	assign cs_fall = ~cs_n_q & cs_n_prev_q;
	assign cs_rise = cs_n_q & ~cs_n_prev_q;
	// A falling shdn implies a complete pulse since reset
	assign shdn_fall = ~shdn_q & shdn_prev_q;
	assign rx_frame = amp_pkg::amp_frame_t'(in_q);

	//////////////////////////////////////////////////////////////////////
	// Frame checks and held setting
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge AMP_CS) begin
		if (reseted) begin
			armed_q <= 1'b0;
			bit_cnt_q <= '0;
			frame_status <= amp_pkg::st_none;
			gain_a <= '0;
			gain_b <= '0;
		end else begin
			if (shdn_fall)
				armed_q <= 1'b1;
			// Saturates so long frames stay long
			if (cs_fall)
				bit_cnt_q <= '0;
			else if (sck_rise && bit_cnt_q != 4'hf)
				bit_cnt_q <= bit_cnt_q + 4'd1;
			if (cs_rise) begin
				if (!armed_q)
					frame_status <= amp_pkg::st_no_reset;
				else if (bit_cnt_q < FRAME_LEN)
					frame_status <= amp_pkg::st_short;
				else if (bit_cnt_q > FRAME_LEN)
					frame_status <= amp_pkg::st_long;
				else if (!code_ok(rx_frame.gain_a) || !code_ok(rx_frame.gain_b))
					frame_status <= amp_pkg::st_bad_code;
				else begin
					frame_status <= amp_pkg::st_ok;
					gain_a <= rx_frame.gain_a;
					gain_b <= rx_frame.gain_b;
				end
			end
		end
	end

	// Shift in on rising sck, shift the held setting out on falling sck
	always_ff @(posedge AMP_CS) begin
		if (sck_rise)
			in_q <= {in_q[`AMP_FRAME_BITS-2:0], mosi_q};
		if (cs_fall)
			out_q <= {gain_a, gain_b};
		else if (sck_fall)
			out_q <= {out_q[`AMP_FRAME_BITS-2:0], 1'b0};
	end

	assign spi.dout = cs_n_q ? 1'b0 : out_q[`AMP_FRAME_BITS-1];

endmodule

// ==== src/amp_gain_top.sv ====
`timescale 1ns/1ps
`include "amp_cfg.svh"

module amp_gain_top (
	input  logic                          AMP_CS,
	input  logic                          reseted,
	// AXI4-Lite slave
	input  logic [`AMP_AXIL_ADDR_W-1:0]   awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`AMP_AXIL_DATA_W-1:0]   wdata,
	input  logic [`AMP_AXIL_DATA_W/8-1:0] wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [`AMP_AXIL_ADDR_W-1:0]   araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [`AMP_AXIL_DATA_W-1:0]   rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	// Gains latched by the amplifier
	output amp_pkg::gain_code_t           gain_a,
	output amp_pkg::gain_code_t           gain_b,
	// Amplifier pins
	output logic                          sck,
	output logic                          mosi,
	output logic                          cs_n,
	output logic                          shdn
);

	logic start;
	logic busy;
	amp_pkg::amp_cmd_t cmd;
	amp_pkg::amp_frame_t gain_word;
	amp_pkg::amp_frame_t readback;
	amp_pkg::frame_status_t frame_status;

	spi_amp_if spi_bus ();

	// Port names match the top one to one
	amp_axil_regs amp_axil_regs_inst (.*);

	amp_spi_master amp_spi_master_inst (
		.AMP_CS    (AMP_CS),
		.reseted   (reseted),
		.start     (start),
		.cmd       (cmd),
		.gain_word (gain_word),
		.busy      (busy),
		.readback  (readback),
		.spi       (spi_bus.master)
	);

	// On-chip emulation of the amplifier
	amp_gain_receiver amp_gain_receiver_inst (
		.AMP_CS       (AMP_CS),
		.reseted      (reseted),
		.spi          (spi_bus.amp),
		.gain_a       (gain_a),
		.gain_b       (gain_b),
		.frame_status (frame_status)
	);

	assign sck = spi_bus.sck;
	assign mosi = spi_bus.mosi;
	assign cs_n = spi_bus.cs_n;
	assign shdn = spi_bus.shdn;

endmodule

// ==== test/amp_gain_model.svh ====
`ifndef AMP_GAIN_MODEL_SVH
`define AMP_GAIN_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference of the amplifier receiver and the register map
//////////////////////////////////////////////////////////////////////

// Set once a complete shdn pulse has gone out
logic exp_armed;
// Gains the amplifier holds, shifted back on dout in the next frame
amp_pkg::amp_frame_t exp_held;
amp_pkg::frame_status_t exp_status;
amp_pkg::amp_frame_t exp_readback;
// Word that the last frame command puts on mosi
amp_pkg::amp_frame_t exp_frame;
// Low byte of the GAIN register
logic [7:0] exp_gain_reg;

// Gain codes 1 to 7 are the only legal ones
function automatic logic legal_code(input logic [3:0] code);
	return (code >= 4'd1) && (code <= 4'd7);
endfunction

function void clear_model();
	exp_armed = 1'b0;
	exp_held = '0;
	exp_status = amp_pkg::st_none;
	exp_readback = '0;
	exp_frame = '0;
	exp_gain_reg = '0;
endfunction

function void predict_shutdown();
	exp_armed = 1'b1;
endfunction

// One full 8-bit frame, readback is whatever was held before it
function void predict_frame(input amp_pkg::amp_frame_t word);
	exp_readback = exp_held;
	exp_frame = word;
	if (!exp_armed)
		exp_status = amp_pkg::st_no_reset;
	else if (!legal_code(word.gain_a) || !legal_code(word.gain_b))
		exp_status = amp_pkg::st_bad_code;
	else begin
		exp_status = amp_pkg::st_ok;
		exp_held = word;
	end
endfunction

// GAIN, CMD and STATUS answer OKAY, anything else SLVERR
function automatic logic [1:0] expected_resp(input logic [3:0] addr);
	if (addr == `AMP_ADDR_GAIN || addr == `AMP_ADDR_CMD || addr == `AMP_ADDR_STATUS)
		return 2'b00;
	return 2'b10;
endfunction

`endif

// ==== test/amp_gain_tb.sv ====
`timescale 1ns/1ps
`include "amp_cfg.svh"

module amp_gain_tb;

	// Cycles from cs_n falling to busy falling
	localparam int FRAME_CYCLES = 2 * `AMP_SCK_DIV * `AMP_FRAME_BITS + `AMP_SCK_DIV + 2;
	// Register writes and status polls around a frame
	localparam int FRAME_OVERHEAD = 40;
	localparam int CYCLE_LIMIT = 40 * (FRAME_CYCLES + FRAME_OVERHEAD) + `AMP_SHDN_CYCLES + 200;
	localparam logic [1:0] SLVERR = 2'b10;

	logic AMP_CS;
	logic reseted;
	logic [`AMP_AXIL_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`AMP_AXIL_DATA_W-1:0] wdata;
	logic [`AMP_AXIL_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`AMP_AXIL_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`AMP_AXIL_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	amp_pkg::gain_code_t gain_a;
	amp_pkg::gain_code_t gain_b;
	logic sck;
	logic mosi;
	logic cs_n;
	logic shdn;

	logic [31:0] rng_state;
	int cycle_cnt = 0;
	int error_cnt;
	int test_cnt;
	int failed_tests;
	int test_err_start;
	string test_name;

	logic sck_last;
	logic cs_n_last;
	logic [7:0] mosi_bits;
	int mosi_cnt;
	int shdn_len;

	`include "amp_gain_model.svh"

	amp_gain_top amp_gain_top_inst (.*);

	initial begin
		AMP_CS = 1'b0;
		forever #5 AMP_CS = ~AMP_CS;
	end

	// Run guard sized for 40 frames
	always @(posedge AMP_CS) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random words and reporting
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Both nibbles in 1 to 7
	function automatic amp_pkg::amp_frame_t good_word();
		logic [31:0] r;
		amp_pkg::amp_frame_t w;
		r = xorshift32();
		w.gain_a = 4'(1 + (r[7:0] % 7));
		w.gain_b = 4'(1 + (r[15:8] % 7));
		return w;
	endfunction

	// At least one nibble is 0 or above 7
	function automatic amp_pkg::amp_frame_t bad_word();
		logic [31:0] r;
		amp_pkg::amp_frame_t w;
		do begin
			r = xorshift32();
			w = r[15:8];
		end while (legal_code(w.gain_a) && legal_code(w.gain_b));
		return w;
	endfunction

	function void flag_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		error_cnt++;
	endfunction

	function void report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_cnt++;
	endfunction

	function void begin_test(input string name);
		test_name = name;
		test_err_start = error_cnt;
		test_cnt++;
	endfunction

	function void end_test();
		if (error_cnt == test_err_start) begin
			$display("Test %0d (%s) passed", test_cnt, test_name);
		end else begin
			failed_tests++;
			$display("Test %0d (%s) failed with %0d errors", test_cnt, test_name,
				error_cnt - test_err_start);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// SPI pin monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled mid cycle, mosi is taken on each rising sck inside a frame
	always @(negedge AMP_CS) begin
		if (reseted) begin
			assert (cs_n && !shdn && !sck && !awready && !arready && !bvalid && !rvalid) else
				report_failure("pins or handshakes not idle during reset");
			sck_last = 1'b0;
			cs_n_last = 1'b1;
			mosi_cnt = 0;
			shdn_len = 0;
		end else begin
			assert (cs_n || !shdn) else
				report_failure("shdn is high while cs_n is low");
			assert (!cs_n || !sck) else
				report_failure("sck is high outside a frame");
			if (shdn) begin
				shdn_len++;
			end else if (shdn_len != 0) begin
				assert (shdn_len == `AMP_SHDN_CYCLES) else
					flag_mismatch($sformatf("shdn pulse of %0d cycles, expected %0d",
						shdn_len, `AMP_SHDN_CYCLES));
				shdn_len = 0;
			end
			if (!cs_n && cs_n_last)
				mosi_cnt = 0;
			if (!cs_n && sck && !sck_last) begin
				mosi_bits = {mosi_bits[6:0], mosi};
				mosi_cnt++;
			end
			if (cs_n && !cs_n_last) begin
				assert (mosi_cnt == `AMP_FRAME_BITS && mosi_bits == exp_frame) else
					flag_mismatch($sformatf("mosi sent %0d bits 0x%02h, expected 0x%02h",
						mosi_cnt, mosi_bits, exp_frame));
			end
			sck_last = sck;
			cs_n_last = cs_n;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite access, entered and left 1 ns after a rising edge
	//////////////////////////////////////////////////////////////////////

	// stalls counts the cycles spent waiting for awready
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, output int stalls);
		stalls = 0;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!awready) begin
			stalls++;
			@(posedge AMP_CS);
			#1;
		end
		assert (wready) else
			report_failure($sformatf("wready low while awready is high for 0x%0h", addr));
		// Accepting edge
		@(posedge AMP_CS);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		assert (bvalid) else
			report_failure($sformatf("no write response after the write to 0x%0h", addr));
		assert (bresp == expected_resp(addr)) else
			flag_mismatch($sformatf("write to 0x%0h answered %0b, expected %0b",
				addr, bresp, expected_resp(addr)));
		if (addr == `AMP_ADDR_GAIN)
			exp_gain_reg = data[7:0];
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready) begin
			@(posedge AMP_CS);
			#1;
		end
		@(posedge AMP_CS);
		#1;
		arvalid = 1'b0;
		assert (rvalid) else
			report_failure($sformatf("no read data after the read of 0x%0h", addr));
		assert (rresp == expected_resp(addr)) else
			flag_mismatch($sformatf("read of 0x%0h answered %0b, expected %0b",
				addr, rresp, expected_resp(addr)));
		data = rdata;
	endtask

	// Poll until idle, then once more since the receiver lags busy
	task automatic wait_idle(output amp_pkg::amp_status_t st);
		logic [31:0] data;
		// busy rises one cycle after the CMD write is taken
		@(posedge AMP_CS);
		#1;
		do begin
			read_reg(`AMP_ADDR_STATUS, data);
			st = data;
		end while (st.busy);
		read_reg(`AMP_ADDR_STATUS, data);
		st = data;
	endtask

	task automatic check_status(input amp_pkg::amp_status_t st, input string what);
		assert (st.frame_status == exp_status) else
			flag_mismatch($sformatf("%s status %0d, expected %0d", what,
				st.frame_status, exp_status));
		assert (st.gain_a == exp_held.gain_a && st.gain_b == exp_held.gain_b) else
			flag_mismatch($sformatf("%s STATUS gains %0d/%0d, expected %0d/%0d", what,
				st.gain_a, st.gain_b, exp_held.gain_a, exp_held.gain_b));
		assert (st.readback == exp_readback) else
			flag_mismatch($sformatf("%s readback 0x%02h, expected 0x%02h", what,
				st.readback, exp_readback));
		assert (gain_a == exp_held.gain_a && gain_b == exp_held.gain_b) else
			flag_mismatch($sformatf("%s gain pins %0d/%0d, expected %0d/%0d", what,
				gain_a, gain_b, exp_held.gain_a, exp_held.gain_b));
	endtask

	task automatic send_frame(input amp_pkg::amp_frame_t w, input string what);
		amp_pkg::amp_status_t st;
		int stalls;
		write_reg(`AMP_ADDR_GAIN, {24'h0, w}, stalls);
		write_reg(`AMP_ADDR_CMD, 32'h1, stalls);
		predict_frame(w);
		wait_idle(st);
		check_status(st, $sformatf("%s 0x%02h", what, w));
	endtask

	task automatic send_shutdown();
		amp_pkg::amp_status_t st;
		int stalls;
		write_reg(`AMP_ADDR_CMD, 32'h2, stalls);
		predict_shutdown();
		wait_idle(st);
		check_status(st, "shutdown");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		amp_pkg::amp_status_t st;
		amp_pkg::amp_frame_t w;
		logic [31:0] data;
		logic [7:0] gain_byte;
		int stalls;
		rng_state = 32'h1b72a78a;
		error_cnt = 0;
		test_cnt = 0;
		failed_tests = 0;
		reseted = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		clear_model();
		repeat (2) @(posedge AMP_CS);
		#1;
		reseted = 1'b0;
		bready = 1'b1;
		rready = 1'b1;

		begin_test("frame before shutdown");
		send_frame(good_word(), "unarmed frame");
		end_test();

		begin_test("legal gain codes");
		send_shutdown();
		repeat (10)
			send_frame(good_word(), "legal frame");
		end_test();

		begin_test("illegal gain codes");
		repeat (8)
			send_frame(bad_word(), "illegal frame");
		end_test();

		// Any byte, mixing legal and illegal frames
		begin_test("readback of held setting");
		repeat (8) begin
			data = xorshift32();
			send_frame(data[23:16], "mixed frame");
		end
		end_test();

		// Second command waits out the first frame and then runs it again
		begin_test("command while busy");
		do
			w = good_word();
		while (w == exp_held);
		write_reg(`AMP_ADDR_GAIN, {24'h0, w}, stalls);
		write_reg(`AMP_ADDR_CMD, 32'h1, stalls);
		predict_frame(w);
		write_reg(`AMP_ADDR_CMD, 32'h1, stalls);
		assert (stalls >= `AMP_SCK_DIV * `AMP_FRAME_BITS) else
			report_failure($sformatf("second command was accepted after %0d cycles", stalls));
		predict_frame(w);
		wait_idle(st);
		check_status(st, "queued frame");
		end_test();

		begin_test("register map");
		read_reg(4'hc, data);
		assert (rresp == SLVERR) else
			flag_mismatch($sformatf("unmapped read answered %0b", rresp));
		write_reg(4'hc, 32'h0, stalls);
		data = xorshift32();
		gain_byte = data[7:0];
		write_reg(`AMP_ADDR_GAIN, {24'h0, gain_byte}, stalls);
		read_reg(`AMP_ADDR_GAIN, data);
		assert (data == {24'h0, exp_gain_reg}) else
			flag_mismatch($sformatf("GAIN read 0x%08h, expected 0x%08h", data,
				{24'h0, exp_gain_reg}));
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", test_cnt, failed_tests, error_cnt);
		if (error_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
+incdir+test
src/amp_pkg.sv
src/spi_amp_if.sv
src/amp_axil_regs.sv
src/amp_spi_master.sv
src/amp_gain_receiver.sv
src/amp_gain_top.sv
test/amp_gain_tb.sv

// ==== Bender.yml ====
package:
  name: amp_gain

sources:
  - include_dirs:
      - src
    files:
      - src/amp_pkg.sv
      - src/spi_amp_if.sv
      - src/amp_axil_regs.sv
      - src/amp_spi_master.sv
      - src/amp_gain_receiver.sv
      - src/amp_gain_top.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/amp_gain_tb.sv
